// ==== hdl/blendPkg.sv ====
//////////////////////////////////////////////////
// Blend package
// Pixel, channel and alpha types of the overlay blender
//////////////////////////////////////////////////
package blendPkg;

  // One colour channel
  typedef logic [7:0] channelT;

  // 0 is fully transparent and 255 fully opaque
  typedef logic [7:0] alphaT;

  // Three channels with red in the top byte
  typedef channelT [2:0] framePixelT;

  // Image pixels carry their own alpha above the colour channels
  typedef struct packed {
    alphaT      alpha;
    framePixelT rgb;
  } imagePixelT;

  // Blender latency from input valid to output valid
  localparam int BLEND_STAGES = 3;

endpackage

// ==== hdl/geometryPkg.sv ====
//////////////////////////////////////////////////
// Geometry package
// Coordinate and line-buffer address definitions
//////////////////////////////////////////////////
package geometryPkg;

  localparam int COORD_WIDTH = 11;
  typedef logic [COORD_WIDTH-1:0] coordT;

  localparam int BUF_AWIDTH = 11;
  typedef logic [BUF_AWIDTH-1:0] bufAddrT;

  // Frame pixels buffered before a line is read back
  localparam bufAddrT READ_START_COUNT = 4;

endpackage

// ==== hdl/overlayParamRegs.sv ====
//////////////////////////////////////////////////
// Overlay parameter registers
// Holds geometry and global alpha, derives the clipped window
//////////////////////////////////////////////////
`timescale 1ns/1ps
module overlayParamRegs (
  input  logic               SYS_CLK_I,
  input  logic               RESET_n_I,
  input  logic               videoParamValid_i,
  input  geometryPkg::coordT fx_i,
  input  geometryPkg::coordT fy_i,
  input  geometryPkg::coordT frameWidth_i,
  input  geometryPkg::coordT frameHeight_i,
  input  geometryPkg::coordT imageWidth_i,
  input  geometryPkg::coordT imageHeight_i,
  input  blendPkg::alphaT    globalAlpha_i,
  output geometryPkg::coordT fxHeld_o,
  output geometryPkg::coordT fyHeld_o,
  output geometryPkg::coordT frameWidthHeld_o,
  output geometryPkg::coordT frameHeightHeld_o,
  output geometryPkg::coordT imageWidthHeld_o,
  output geometryPkg::coordT imageHeightHeld_o,
  output blendPkg::alphaT    globalAlphaHeld_o,
  output geometryPkg::coordT windowEndX_o,
  output geometryPkg::coordT windowEndY_o
);

  // One extra bit so that offset plus size cannot wrap
  logic [geometryPkg::COORD_WIDTH:0] spanX;
  logic [geometryPkg::COORD_WIDTH:0] spanY;
  geometryPkg::coordT                endX;
  geometryPkg::coordT                endY;

  assign spanX = {1'b0, fx_i} + {1'b0, imageWidth_i};
  assign spanY = {1'b0, fy_i} + {1'b0, imageHeight_i};

  // Last window column and row, clipped at the frame edge
  assign endX = (spanX < {1'b0, frameWidth_i}) ? geometryPkg::coordT'(spanX - 1'b1)
                                               : frameWidth_i - 1'b1;
  assign endY = (spanY < {1'b0, frameHeight_i}) ? geometryPkg::coordT'(spanY - 1'b1)
                                                : frameHeight_i - 1'b1;

  always_ff @(posedge SYS_CLK_I)
  begin
    if (!RESET_n_I)
    begin
      fxHeld_o          <= '0;
      fyHeld_o          <= '0;
      frameWidthHeld_o  <= '0;
      frameHeightHeld_o <= '0;
      imageWidthHeld_o  <= '0;
      imageHeightHeld_o <= '0;
      globalAlphaHeld_o <= '0;
      windowEndX_o      <= '0;
      windowEndY_o      <= '0;
    end
    else if (videoParamValid_i)
    begin
      fxHeld_o          <= fx_i;
      fyHeld_o          <= fy_i;
      frameWidthHeld_o  <= frameWidth_i;
      frameHeightHeld_o <= frameHeight_i;
      imageWidthHeld_o  <= imageWidth_i;
      imageHeightHeld_o <= imageHeight_i;
      globalAlphaHeld_o <= globalAlpha_i;
      windowEndX_o      <= endX;
      windowEndY_o      <= endY;
    end
  end

endmodule

// ==== hdl/lineBuffer.sv ====
//////////////////////////////////////////////////
// Line buffer
// One video line, written in order and read at random
//////////////////////////////////////////////////
`timescale 1ns/1ps
module lineBuffer #(
  parameter type pixelT     = logic [7:0],
  parameter int  ADDR_WIDTH = 11
) (
  input  logic                  SYS_CLK_I,
  input  logic                  RESET_n_I,
  input  logic                  writeValid_i,
  input  pixelT                 writeData_i,
  input  geometryPkg::coordT    lineLength_i,
  input  logic [ADDR_WIDTH-1:0] readAddr_i,
  output pixelT                 readData_o,
  output logic [ADDR_WIDTH-1:0] writeCount_o
);

  pixelT                 mem [0:(1 << ADDR_WIDTH)-1];
  logic                  writeValidQ;
  pixelT                 writeDataQ;
  logic [ADDR_WIDTH-1:0] writeAddr;
  logic [ADDR_WIDTH-1:0] lastAddr;

  assign lastAddr     = ADDR_WIDTH'(lineLength_i - 1'b1);
  assign writeCount_o = writeAddr;

  // Input stage
  always_ff @(posedge SYS_CLK_I)
  begin
    if (!RESET_n_I)
    begin
      writeValidQ <= 1'b0;
    end
    else
    begin
      writeValidQ <= writeValid_i;
    end
    writeDataQ <= writeData_i;
  end

  // The address returns to zero after the last pixel of a line
  always_ff @(posedge SYS_CLK_I)
  begin
    if (!RESET_n_I)
    begin
      writeAddr <= '0;
    end
    else if (writeValidQ)
    begin
      writeAddr <= (writeAddr == lastAddr) ? '0 : writeAddr + 1'b1;
    end
  end

  always_ff @(posedge SYS_CLK_I)
  begin
    if (writeValidQ)
    begin
      mem[writeAddr] <= writeDataQ;
    end
    readData_o <= mem[readAddr_i];
  end

endmodule

// ==== hdl/overlayScanner.sv ====
//////////////////////////////////////////////////
// Overlay scanner
// Reads frame lines back and marks the overlay window
//////////////////////////////////////////////////
`timescale 1ns/1ps
module overlayScanner (
  input  logic                 SYS_CLK_I,
  input  logic                 RESET_n_I,
  input  geometryPkg::bufAddrT frameWriteCount_i,
  input  geometryPkg::coordT   fxHeld_i,
  input  geometryPkg::coordT   fyHeld_i,
  input  geometryPkg::coordT   frameWidthHeld_i,
  input  geometryPkg::coordT   frameHeightHeld_i,
  input  geometryPkg::coordT   windowEndX_i,
  input  geometryPkg::coordT   windowEndY_i,
  output geometryPkg::bufAddrT frameReadAddr_o,
  output geometryPkg::bufAddrT imageReadAddr_o,
  output logic                 readValid_o,
  output logic                 inWindow_o,
  output logic                 lastInLine_o,
  output logic                 lastInFrame_o
);

  typedef enum logic {
    scanIdle,
    scanRead
  } scanStateT;

  scanStateT          state;
  geometryPkg::coordT col;
  geometryPkg::coordT row;
  logic               lastCol;
  logic               lastRow;
  logic               colInside;
  logic               rowInside;

  assign lastCol = (col == frameWidthHeld_i - 1'b1);
  assign lastRow = (row == frameHeightHeld_i - 1'b1);

  // Read sequencing, one column per cycle once enough pixels are stored
  always_ff @(posedge SYS_CLK_I)
  begin
    if (!RESET_n_I)
    begin
      state <= scanIdle;
      col   <= '0;
      row   <= '0;
    end
    else
    begin
      case (state)
        scanIdle:
        begin
          col <= '0;
          if (frameWriteCount_i == geometryPkg::READ_START_COUNT)
          begin
            state <= scanRead;
          end
        end
        scanRead:
        begin
          if (lastCol)
          begin
            state <= scanIdle;
            col   <= '0;
            row   <= lastRow ? '0 : row + 1'b1;
          end
          else
          begin
            col <= col + 1'b1;
          end
        end
        default:
        begin
          state <= scanIdle;
        end
      endcase
    end
  end

  assign colInside = (col >= fxHeld_i) && (col <= windowEndX_i);
  assign rowInside = (row >= fyHeld_i) && (row <= windowEndY_i);

  assign readValid_o     = (state == scanRead);
  assign frameReadAddr_o = geometryPkg::bufAddrT'(col);
  // Image pixels sit in their buffer relative to the window's left edge
  assign imageReadAddr_o = geometryPkg::bufAddrT'(col - fxHeld_i);
  assign inWindow_o      = readValid_o && colInside && rowInside;
  assign lastInLine_o    = readValid_o && lastCol;
  assign lastInFrame_o   = readValid_o && lastCol && lastRow;

endmodule

// ==== hdl/alphaBlender.sv ====
//////////////////////////////////////////////////
// Alpha blender
// Three-stage per-channel mix of image over frame
//////////////////////////////////////////////////
`timescale 1ns/1ps
module alphaBlender #(
  parameter int PIPE_DEPTH = 3
) (
  input  logic                 SYS_CLK_I,
  input  logic                 RESET_n_I,
  input  logic                 valid_i,
  input  logic                 inWindow_i,
  input  logic                 lastInLine_i,
  input  logic                 lastInFrame_i,
  input  blendPkg::framePixelT framePixel_i,
  input  blendPkg::imagePixelT imagePixel_i,
  input  blendPkg::alphaT      globalAlpha_i,
  output blendPkg::framePixelT vout_o,
  output logic                 voutValid_o,
  output logic                 lineDone_o,
  output logic                 frameDone_o
);

  logic [15:0]          alphaProduct;
  blendPkg::alphaT      alphaS1;
  blendPkg::framePixelT frameS1;
  blendPkg::framePixelT imageS1;
  logic [15:0]          mixS2 [0:2];
  logic [PIPE_DEPTH-1:0] validPipe;
  logic [PIPE_DEPTH-1:0] linePipe;
  logic [PIPE_DEPTH-1:0] framePipe;

  assign alphaProduct = imagePixel_i.alpha * globalAlpha_i;

  always_ff @(posedge SYS_CLK_I)
  begin
    // Stage 1: scale the image alpha, zero outside the window
    alphaS1 <= inWindow_i ? alphaProduct[15:8] : '0;
    frameS1 <= framePixel_i;
    imageS1 <= imagePixel_i.rgb;
    for (int ch = 0; ch < 3; ch++)
    begin
      // Stage 2: weighted sum, weights add up to 256
      mixS2[ch] <= imageS1[ch] * alphaS1 + frameS1[ch] * (9'd256 - alphaS1);
      // Stage 3
      vout_o[ch] <= mixS2[ch][15:8];
    end
  end

  // Valid and markers follow the data through the pipe
  always_ff @(posedge SYS_CLK_I)
  begin
    if (!RESET_n_I)
    begin
      validPipe <= '0;
      linePipe  <= '0;
      framePipe <= '0;
    end
    else
    begin
      validPipe <= {validPipe[PIPE_DEPTH-2:0], valid_i};
      linePipe  <= {linePipe[PIPE_DEPTH-2:0], valid_i & lastInLine_i};
      framePipe <= {framePipe[PIPE_DEPTH-2:0], valid_i & lastInFrame_i};
    end
  end

  assign voutValid_o = validPipe[PIPE_DEPTH-1];
  assign lineDone_o  = linePipe[PIPE_DEPTH-1];
  assign frameDone_o = framePipe[PIPE_DEPTH-1];

endmodule

// ==== hdl/alphaBlendTop.sv ====
//////////////////////////////////////////////////
// Overlay blend top level
// Buffers frame and image lines and blends the window
//////////////////////////////////////////////////
`timescale 1ns/1ps
module alphaBlendTop (
  input  logic                 SYS_CLK_I,
  input  logic                 RESET_n_I,
  input  logic                 videoParamValid_i,
  input  geometryPkg::coordT   fx_i,
  input  geometryPkg::coordT   fy_i,
  input  geometryPkg::coordT   frameWidth_i,
  input  geometryPkg::coordT   frameHeight_i,
  input  geometryPkg::coordT   imageWidth_i,
  input  geometryPkg::coordT   imageHeight_i,
  input  blendPkg::alphaT      globalAlpha_i,
  input  logic                 frameValid_i,
  input  blendPkg::framePixelT frameData_i,
  input  logic                 imageValid_i,
  input  blendPkg::imagePixelT imageData_i,
  output blendPkg::framePixelT vout_o,
  output logic                 voutValid_o,
  output logic                 lineDone_o,
  output logic                 frameDone_o
);

  geometryPkg::coordT   fxHeld;
  geometryPkg::coordT   fyHeld;
  geometryPkg::coordT   frameWidthHeld;
  geometryPkg::coordT   frameHeightHeld;
  geometryPkg::coordT   imageWidthHeld;
  geometryPkg::coordT   windowEndX;
  geometryPkg::coordT   windowEndY;
  blendPkg::alphaT      globalAlphaHeld;
  geometryPkg::bufAddrT frameWriteCount;
  geometryPkg::bufAddrT frameReadAddr;
  geometryPkg::bufAddrT imageReadAddr;
  blendPkg::framePixelT frameReadData;
  blendPkg::imagePixelT imageReadData;
  logic                 readValid;
  logic                 inWindow;
  logic                 lastInLine;
  logic                 lastInFrame;
  logic                 readValidQ;
  logic                 inWindowQ;
  logic                 lastInLineQ;
  logic                 lastInFrameQ;

  overlayParamRegs overlayParamRegs_inst (
    .SYS_CLK_I         (SYS_CLK_I),
    .RESET_n_I         (RESET_n_I),
    .videoParamValid_i (videoParamValid_i),
    .fx_i              (fx_i),
    .fy_i              (fy_i),
    .frameWidth_i      (frameWidth_i),
    .frameHeight_i     (frameHeight_i),
    .imageWidth_i      (imageWidth_i),
    .imageHeight_i     (imageHeight_i),
    .globalAlpha_i     (globalAlpha_i),
    .fxHeld_o          (fxHeld),
    .fyHeld_o          (fyHeld),
    .frameWidthHeld_o  (frameWidthHeld),
    .frameHeightHeld_o (frameHeightHeld),
    .imageWidthHeld_o  (imageWidthHeld),
    .imageHeightHeld_o (),
    .globalAlphaHeld_o (globalAlphaHeld),
    .windowEndX_o      (windowEndX),
    .windowEndY_o      (windowEndY)
  );

  lineBuffer #(
    .pixelT     (blendPkg::framePixelT),
    .ADDR_WIDTH (geometryPkg::BUF_AWIDTH)
  ) frameBuffer_inst (
    .SYS_CLK_I    (SYS_CLK_I),
    .RESET_n_I    (RESET_n_I),
    .writeValid_i (frameValid_i),
    .writeData_i  (frameData_i),
    .lineLength_i (frameWidthHeld),
    .readAddr_i   (frameReadAddr),
    .readData_o   (frameReadData),
    .writeCount_o (frameWriteCount)
  );

  lineBuffer #(
    .pixelT     (blendPkg::imagePixelT),
    .ADDR_WIDTH (geometryPkg::BUF_AWIDTH)
  ) imageBuffer_inst (
    .SYS_CLK_I    (SYS_CLK_I),
    .RESET_n_I    (RESET_n_I),
    .writeValid_i (imageValid_i),
    .writeData_i  (imageData_i),
    .lineLength_i (imageWidthHeld),
    .readAddr_i   (imageReadAddr),
    .readData_o   (imageReadData),
    .writeCount_o ()
  );

  overlayScanner overlayScanner_inst (
    .SYS_CLK_I         (SYS_CLK_I),
    .RESET_n_I         (RESET_n_I),
    .frameWriteCount_i (frameWriteCount),
    .fxHeld_i          (fxHeld),
    .fyHeld_i          (fyHeld),
    .frameWidthHeld_i  (frameWidthHeld),
    .frameHeightHeld_i (frameHeightHeld),
    .windowEndX_i      (windowEndX),
    .windowEndY_i      (windowEndY),
    .frameReadAddr_o   (frameReadAddr),
    .imageReadAddr_o   (imageReadAddr),
    .readValid_o       (readValid),
    .inWindow_o        (inWindow),
    .lastInLine_o      (lastInLine),
    .lastInFrame_o     (lastInFrame)
  );

  // Buffer reads take a cycle, so the flags wait one cycle too
  always_ff @(posedge SYS_CLK_I)
  begin
    if (!RESET_n_I)
    begin
      readValidQ   <= 1'b0;
      inWindowQ    <= 1'b0;
      lastInLineQ  <= 1'b0;
      lastInFrameQ <= 1'b0;
    end
    else
    begin
      readValidQ   <= readValid;
      inWindowQ    <= inWindow;
      lastInLineQ  <= lastInLine;
      lastInFrameQ <= lastInFrame;
    end
  end

  alphaBlender #(
    .PIPE_DEPTH (blendPkg::BLEND_STAGES)
  ) alphaBlender_inst (
    .SYS_CLK_I     (SYS_CLK_I),
    .RESET_n_I     (RESET_n_I),
    .valid_i       (readValidQ),
    .inWindow_i    (inWindowQ),
    .lastInLine_i  (lastInLineQ),
    .lastInFrame_i (lastInFrameQ),
    .framePixel_i  (frameReadData),
    .imagePixel_i  (imageReadData),
    .globalAlpha_i (globalAlphaHeld),
    .vout_o        (vout_o),
    .voutValid_o   (voutValid_o),
    .lineDone_o    (lineDone_o),
    .frameDone_o   (frameDone_o)
  );

endmodule

// ==== sim/overlayTiming_checker.sv ====
//////////////////////////////////////////////////
// Overlay timing checker
// Assertions on the valid and marker outputs
//////////////////////////////////////////////////
`timescale 1ns/1ps
module overlayTiming_checker (
  input logic                 SYS_CLK_I,
  input logic                 RESET_n_I,
  input blendPkg::framePixelT vout_i,
  input logic                 voutValid_i,
  input logic                 lineDone_i,
  input logic                 frameDone_i
);

  int assertErrors = 0;

  controlKnown: assert property (@(posedge SYS_CLK_I) disable iff (!RESET_n_I)
    !$isunknown({voutValid_i, lineDone_i, frameDone_i}))
    else
    begin
      $error("Output valid or marker is unknown");
      assertErrors++;
    end

  // Pixel data only has to be known while it is marked valid
  dataKnown: assert property (@(posedge SYS_CLK_I) disable iff (!RESET_n_I)
    voutValid_i |-> !$isunknown(vout_i))
    else
    begin
      $error("Valid output pixel is unknown");
      assertErrors++;
    end

  lineNeedsValid: assert property (@(posedge SYS_CLK_I) disable iff (!RESET_n_I)
    lineDone_i |-> voutValid_i)
    else
    begin
      $error("Line marker without a valid pixel");
      assertErrors++;
    end

  frameNeedsLine: assert property (@(posedge SYS_CLK_I) disable iff (!RESET_n_I)
    frameDone_i |-> lineDone_i)
    else
    begin
      $error("Frame marker without a line marker");
      assertErrors++;
    end

  quietInReset: assert property (@(posedge SYS_CLK_I)
    !RESET_n_I |=> !(voutValid_i || lineDone_i || frameDone_i))
    else
    begin
      $error("Output active during reset");
      assertErrors++;
    end

endmodule

bind alphaBlendTop overlayTiming_checker overlayTimingChecker_inst (
  .SYS_CLK_I   (SYS_CLK_I),
  .RESET_n_I   (RESET_n_I),
  .vout_i      (vout_o),
  .voutValid_i (voutValid_o),
  .lineDone_i  (lineDone_o),
  .frameDone_i (frameDone_o)
);

// ==== sim/blendMonitor.sv ====
//////////////////////////////////////////////////
// Blend monitor
// Predicts every output pixel and marker, counts errors
//////////////////////////////////////////////////
`timescale 1ns/1ps
module blendMonitor (
  input logic                 SYS_CLK_I,
  input logic                 RESET_n_I,
  input blendPkg::framePixelT vout_i,
  input logic                 voutValid_i,
  input logic                 lineDone_i,
  input logic                 frameDone_i
);

  localparam int IMAGE_SPAN = 64;

  blendPkg::framePixelT frameQ [$];
  logic [31:0]          imageMem [0:IMAGE_SPAN*IMAGE_SPAN-1];
  int fw = 0;
  int fh = 0;
  int fx = 0;
  int fy = 0;
  int ga = 0;
  int endX = -1;
  int endY = -1;
  int expBlend = 0;
  int expOut = 0;
  int col = 0;
  int row = 0;
  int outCount = 0;
  int blendCount = 0;
  int lineCount = 0;
  int frameCount = 0;
  int pixelErrors = 0;
  int markerErrors = 0;
  int countErrors = 0;

  task startTest(input int frameW, frameH, offX, offY, imageW, imageH, alphaG,
                 blendExp, outExp);
    fw = frameW;
    fh = frameH;
    fx = offX;
    fy = offY;
    ga = alphaG;
    // Window end is clipped at the frame edge
    endX = ((offX + imageW < frameW) ? offX + imageW : frameW) - 1;
    endY = ((offY + imageH < frameH) ? offY + imageH : frameH) - 1;
    expBlend = blendExp;
    expOut = outExp;
    col = 0;
    row = 0;
    outCount = 0;
    blendCount = 0;
    lineCount = 0;
    frameCount = 0;
    frameQ.delete();
  endtask

  task pushFrame(input blendPkg::framePixelT pix);
    frameQ.push_back(pix);
  endtask

  task storeImage(input int imageRow, imageCol, input logic [31:0] pix);
    imageMem[imageRow*IMAGE_SPAN + imageCol] = pix;
  endtask

  task automatic checkPixel;
    blendPkg::framePixelT framePix;
    blendPkg::framePixelT expected;
    logic [31:0]          imagePix;
    logic                 inWin;
    logic                 expLine;
    logic                 expFrame;
    int                   alpha;
    int                   mix;
    int                   ch;
    if (frameQ.size() == 0)
    begin
      $display("Output pixel at column %0d row %0d has no frame pixel behind it", col, row);
      pixelErrors++;
    end
    else
    begin
      framePix = frameQ.pop_front();
      inWin = (col >= fx) && (col <= endX) && (row >= fy) && (row <= endY);
      imagePix = inWin ? imageMem[(row - fy)*IMAGE_SPAN + (col - fx)] : 32'h0;
      alpha = inWin ? (imagePix[31:24] * ga) >> 8 : 0;
      for (ch = 0; ch < 3; ch++)
      begin
        mix = imagePix[ch*8 +: 8] * alpha + framePix[ch] * (256 - alpha);
        expected[ch] = blendPkg::channelT'(mix >> 8);
      end
      if (vout_i !== expected)
      begin
        $display("** Error vout_o: got %h expected %h at column %0d row %0d",
                 vout_i, expected, col, row);
        pixelErrors++;
      end
      if (inWin)
        blendCount++;
    end
    expLine = (col == fw - 1);
    expFrame = expLine && (row == fh - 1);
    if (lineDone_i !== expLine)
    begin
      $display("** Error lineDone_o: got %h expected %h at column %0d row %0d",
               lineDone_i, expLine, col, row);
      markerErrors++;
    end
    if (frameDone_i !== expFrame)
    begin
      $display("** Error frameDone_o: got %h expected %h at column %0d row %0d",
               frameDone_i, expFrame, col, row);
      markerErrors++;
    end
    lineCount += lineDone_i;
    frameCount += frameDone_i;
    outCount++;
    if (expLine)
    begin
      col = 0;
      row++;
    end
    else
      col++;
  endtask

  // Outputs change on the rising edge and are read half a cycle later
  always @(negedge SYS_CLK_I)
  begin
    if (RESET_n_I && voutValid_i)
      checkPixel();
    else if (RESET_n_I && (lineDone_i || frameDone_i))
    begin
      $display("A marker pulsed without a valid output pixel");
      markerErrors++;
    end
  end

  task finishTest(input int testNum);
    if (outCount != expOut)
    begin
      $display("Test %0d gave %0d output pixels instead of %0d", testNum, outCount, expOut);
      countErrors++;
    end
    if (blendCount != expBlend)
    begin
      $display("Test %0d blended %0d pixels instead of %0d", testNum, blendCount, expBlend);
      countErrors++;
    end
    if (lineCount != fh || frameCount != 1)
    begin
      $display("Test %0d gave %0d line markers and %0d frame markers for %0d rows",
               testNum, lineCount, frameCount, fh);
      countErrors++;
    end
    if (frameQ.size() != 0)
    begin
      $display("Test %0d left %0d frame pixels without output", testNum, frameQ.size());
      countErrors++;
    end
  endtask

endmodule

// ==== sim/alphaBlendTb.sv ====
//////////////////////////////////////////////////
// Overlay blender testbench
// File-driven frames with random pixels against the monitor
//////////////////////////////////////////////////
`timescale 1ns/1ps
module alphaBlendTb;

  localparam int MAX_TESTS = 32;
  localparam int PRELOAD_CYCLES = 2048;

  logic                 SYS_CLK_I;
  logic                 RESET_n_I;
  logic                 videoParamValid_i;
  geometryPkg::coordT   fx_i;
  geometryPkg::coordT   fy_i;
  geometryPkg::coordT   frameWidth_i;
  geometryPkg::coordT   frameHeight_i;
  geometryPkg::coordT   imageWidth_i;
  geometryPkg::coordT   imageHeight_i;
  blendPkg::alphaT      globalAlpha_i;
  logic                 frameValid_i;
  blendPkg::framePixelT frameData_i;
  logic                 imageValid_i;
  blendPkg::imagePixelT imageData_i;
  blendPkg::framePixelT vout_o;
  logic                 voutValid_o;
  logic                 lineDone_o;
  logic                 frameDone_o;

  int          testSet [0:MAX_TESTS-1][0:8];
  int          testCount = 0;
  int          fileErrors = 0;
  int          assertErrors;
  int          errorTotal;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  logic [31:0] rngState = 32'h968eef44;

  alphaBlendTop alphaBlendTop_inst (.*);

  blendMonitor blendMonitor_inst (
    .SYS_CLK_I   (SYS_CLK_I),
    .RESET_n_I   (RESET_n_I),
    .vout_i      (vout_o),
    .voutValid_i (voutValid_o),
    .lineDone_i  (lineDone_o),
    .frameDone_i (frameDone_o)
  );

  initial
  begin
    SYS_CLK_I = 1'b0;
    forever #20 SYS_CLK_I = ~SYS_CLK_I;
  end

  always @(posedge SYS_CLK_I)
  begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit)
    begin
      $display("Timeout after %0d cycles, the tests did not complete", cycleCount);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshiftNext(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task readTests;
    int    fd;
    int    n;
    int    v [0:8];
    string line;
    fd = $fopen("sim/blendTests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test file sim/blendTests.txt");
      fileErrors++;
    end
    else
    begin
      while (!$feof(fd) && testCount < MAX_TESTS)
      begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#")
        begin
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
          if (n == 9)
          begin
            testSet[testCount] = v;
            testCount++;
          end
        end
      end
      $fclose(fd);
      if (testCount == 0)
      begin
        $display("The test file holds no usable test lines");
        fileErrors++;
      end
    end
  endtask

  task strobeParams(input int fw, fh, fx, fy, iw, ih, ga);
    @(negedge SYS_CLK_I);
    videoParamValid_i = 1'b1;
    fx_i = geometryPkg::coordT'(fx);
    fy_i = geometryPkg::coordT'(fy);
    frameWidth_i = geometryPkg::coordT'(fw);
    frameHeight_i = geometryPkg::coordT'(fh);
    imageWidth_i = geometryPkg::coordT'(iw);
    imageHeight_i = geometryPkg::coordT'(ih);
    globalAlpha_i = blendPkg::alphaT'(ga);
    @(negedge SYS_CLK_I);
    videoParamValid_i = 1'b0;
  endtask

  // A zero image width wraps the write address over the whole image buffer,
  // so positions outside any window still read back known data
  task preloadImageBuffer;
    int addr;
    strobeParams(0, 0, 0, 0, 0, 0, 0);
    for (addr = 0; addr < PRELOAD_CYCLES; addr++)
    begin
      imageValid_i = 1'b1;
      imageData_i = {addr[10:0], ~addr[10:0], 10'h2a5};
      @(negedge SYS_CLK_I);
    end
    imageValid_i = 1'b0;
  endtask

  task runTest(input int t);
    int          fw, fh, fx, fy, iw, ih, ga;
    int          row;
    int          col;
    int          lineLen;
    logic [31:0] imagePix;
    fw = testSet[t][0];
    fh = testSet[t][1];
    fx = testSet[t][2];
    fy = testSet[t][3];
    iw = testSet[t][4];
    ih = testSet[t][5];
    ga = testSet[t][6];
    blendMonitor_inst.startTest(fw, fh, fx, fy, iw, ih, ga, testSet[t][7], testSet[t][8]);
    strobeParams(fw, fh, fx, fy, iw, ih, ga);
    @(negedge SYS_CLK_I);
    lineLen = (iw > fw) ? iw : fw;
    for (row = 0; row < fh; row++)
    begin
      for (col = 0; col < lineLen; col++)
      begin
        frameValid_i = (col < fw);
        imageValid_i = 1'b0;
        if (col < fw)
        begin
          rngState = xorshiftNext(rngState);
          frameData_i = rngState[23:0];
          blendMonitor_inst.pushFrame(rngState[23:0]);
        end
        if (row >= fy && row < fy + ih && col < iw)
        begin
          rngState = xorshiftNext(rngState);
          imagePix = rngState;
          // About one image pixel in four is fully opaque
          if (imagePix[29:28] == 2'b00)
            imagePix[31:24] = 8'hff;
          imageValid_i = 1'b1;
          imageData_i = imagePix;
          blendMonitor_inst.storeImage(row - fy, col, imagePix);
        end
        @(negedge SYS_CLK_I);
      end
      frameValid_i = 1'b0;
      imageValid_i = 1'b0;
      while (!lineDone_o)
        @(negedge SYS_CLK_I);
    end
    @(negedge SYS_CLK_I);
    blendMonitor_inst.finishTest(t);
  endtask

  initial
  begin
    RESET_n_I = 1'b0;
    videoParamValid_i = 1'b0;
    fx_i = '0;
    fy_i = '0;
    frameWidth_i = '0;
    frameHeight_i = '0;
    imageWidth_i = '0;
    imageHeight_i = '0;
    globalAlpha_i = '0;
    frameValid_i = 1'b0;
    frameData_i = '0;
    imageValid_i = 1'b0;
    imageData_i = '0;
    readTests();
    cycleLimit = PRELOAD_CYCLES + 200;
    for (int t = 0; t < testCount; t++)
      cycleLimit += (testSet[t][0] + 8) * testSet[t][1];
    repeat (8) @(negedge SYS_CLK_I);
    RESET_n_I = 1'b1;
    if (fileErrors == 0)
    begin
      preloadImageBuffer();
      for (int t = 0; t < testCount; t++)
        runTest(t);
    end
    assertErrors = alphaBlendTop_inst.overlayTimingChecker_inst.assertErrors;
    errorTotal = blendMonitor_inst.pixelErrors + blendMonitor_inst.markerErrors
                 + blendMonitor_inst.countErrors + fileErrors + assertErrors;
    $display("Errors: %0d pixel, %0d marker, %0d count, %0d file, %0d assertion",
             blendMonitor_inst.pixelErrors, blendMonitor_inst.markerErrors,
             blendMonitor_inst.countErrors, fileErrors, assertErrors);
    if (errorTotal == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== sim/blendTests.txt ====
# frameWidth frameHeight fx fy imageWidth imageHeight globalAlpha blended outputs
# All values decimal, window cells are counted after clipping at the frame edges
16 8 4 2 6 3 200 18 128
16 8 12 2 8 4 255 16 128
12 10 3 7 5 6 128 15 120
10 6 6 4 8 8 96 8 60
8 4 0 0 8 4 0 32 32
20 5 0 0 3 2 255 6 100
9 7 8 6 1 1 170 1 63
24 3 2 1 20 1 255 20 72
8 3 9 0 2 3 255 0 24
14 6 5 1 4 4 0 16 84
32 4 1 3 31 5 255 31 128
6 6 2 2 2 2 64 4 36

// ==== src.f ====
hdl/blendPkg.sv
hdl/geometryPkg.sv
hdl/overlayParamRegs.sv
hdl/lineBuffer.sv
hdl/overlayScanner.sv
hdl/alphaBlender.sv
hdl/alphaBlendTop.sv
sim/overlayTiming_checker.sv
sim/blendMonitor.sv
sim/alphaBlendTb.sv

// ==== Bender.yml ====
package:
  name: alpha_blend

sources:
  - hdl/blendPkg.sv
  - hdl/geometryPkg.sv
  - hdl/overlayParamRegs.sv
  - hdl/lineBuffer.sv
  - hdl/overlayScanner.sv
  - hdl/alphaBlender.sv
  - hdl/alphaBlendTop.sv
  - target: simulation
    files:
      - sim/overlayTiming_checker.sv
      - sim/blendMonitor.sv
      - sim/alphaBlendTb.sv
